/* Bender.yml */
package:
  name: piarb

sources:
  # shared package first, then the RTL in compile order
  - files:
      - common/piarb_pkg.sv
      - logic/piarb_value_ram.sv
      - logic/piarb_cfg_port.sv
      - piarb_lookup/piarb_lookup.sv
      - logic/piarb_top.sv

  # testbench, top module piarb_tb
  - target: test
    files:
      - tb/piarb_clk_gen.sv
      - tb/piarb_tb.sv

/* common/piarb_pkg.sv */
// widths, latency, packet type and config target enums, in and out metadata structs
package piarb_pkg;

	// field widths of the hop word and its metadata
	localparam int fid_nbits        = 6;   // 64 flow table entries
	localparam int tid_nbits        = 4;   // 16 topic table entries
	localparam int pu_id_nbits      = 3;
	localparam int hop_info_nbits   = 32;
	localparam int flow_pu_nbits    = 16;
	localparam int switch_tag_nbits = 12;
	localparam int time_nbits       = 16;
	localparam int rci_nbits        = 2;

	// data_ack_valid to piarb_pu_valid, in clock cycles
	localparam int lookup_latency = 4;

	// packet type as seen by the processing unit
	typedef enum logic [1:0] {
		pkt_plain = 2'd0,
		pkt_type1 = 2'd2
	} pkt_type_e;

	// table addressed by one configuration transfer
	typedef enum logic {
		cfg_flow  = 1'b0,
		cfg_topic = 1'b1
	} cfg_target_e;

	// metadata arriving with each hop word
	typedef struct packed {
		logic [time_nbits-1:0] creation_time;
		logic [rci_nbits-1:0]  rci;
		logic                  type1;    // selects pkt_type1 on the way out
		logic                  fid_sel;
		logic [fid_nbits-1:0]  fid;
		logic [tid_nbits-1:0]  tid;
	} pp_piarb_meta_t;

	// metadata handed to the processing unit after the lookup
	typedef struct packed {
		logic [time_nbits-1:0]       creation_time;
		logic [rci_nbits-1:0]        rci_type;
		pkt_type_e                   pkt_type;
		logic [switch_tag_nbits-1:0] switch_tag;   // from the topic table
		logic [flow_pu_nbits-1:0]    f_payload;    // from the flow table
		logic [fid_nbits-1:0]        fid;
		logic [tid_nbits-1:0]        tid;
	} pu_hop_meta_t;

endpackage

/* logic/piarb_cfg_port.sv */
// four-phase req/ack configuration slave issuing single flow or topic table writes
`timescale 1ns/100ps

module piarb_cfg_port (
	input  logic                                     clk,
	input  logic                                     rst_n,

	input  logic                                     cfg_req,
	input  piarb_pkg::cfg_target_e                   cfg_target,
	input  logic [piarb_pkg::fid_nbits-1:0]          cfg_addr,
	input  logic [piarb_pkg::flow_pu_nbits-1:0]      cfg_wdata,
	output logic                                     cfg_ack,

	output logic                                     flow_cfg_wr,
	output logic [piarb_pkg::fid_nbits-1:0]          flow_cfg_addr,
	output logic [piarb_pkg::flow_pu_nbits-1:0]      flow_cfg_wdata,

	output logic                                     topic_wr,
	output logic [piarb_pkg::tid_nbits-1:0]          topic_waddr,
	output logic [piarb_pkg::switch_tag_nbits-1:0]   topic_wdata
);

	typedef enum logic [2:0] {
		st_idle,
		st_write,     // write strobe high for this one cycle
		st_settle,    // flow write crosses the lookup register
		st_ack,
		st_release
	} cfg_state_e;

	cfg_state_e                           state;
	piarb_pkg::cfg_target_e               target_q;
	logic [piarb_pkg::fid_nbits-1:0]      addr_q;
	logic [piarb_pkg::flow_pu_nbits-1:0]  wdata_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= st_idle;
			target_q <= piarb_pkg::cfg_flow;
		end else begin
			case (state)
				st_idle: begin
					if (cfg_req) begin
						state    <= st_write;
						target_q <= cfg_target;   // request sampled only once
					end
				end
				st_write:  state <= st_settle;
				st_settle: state <= st_ack;
				st_ack: begin
					if (!cfg_req) begin
						state <= st_release;   // master has seen the ack
					end
				end
				st_release: state <= st_idle;
				default:    state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && cfg_req) begin
			addr_q  <= cfg_addr;
			wdata_q <= cfg_wdata;
		end
	end

	assign cfg_ack = (state == st_ack);

	assign flow_cfg_wr    = (state == st_write) && (target_q == piarb_pkg::cfg_flow);
	assign flow_cfg_addr  = addr_q;
	assign flow_cfg_wdata = wdata_q;

	// the topic table only uses the low address and data bits
	assign topic_wr    = (state == st_write) && (target_q == piarb_pkg::cfg_topic);
	assign topic_waddr = addr_q[piarb_pkg::tid_nbits-1:0];
	assign topic_wdata = wdata_q[piarb_pkg::switch_tag_nbits-1:0];

endmodule

/* logic/piarb_top.sv */
// lookup stage top: configuration port, lookup pipeline, flow and topic tables
`timescale 1ns/100ps

module piarb_top (
	input  logic                                     clk,
	input  logic                                     rst_n,

	input  logic                                     cfg_req,
	input  piarb_pkg::cfg_target_e                   cfg_target,
	input  logic [piarb_pkg::fid_nbits-1:0]          cfg_addr,
	input  logic [piarb_pkg::flow_pu_nbits-1:0]      cfg_wdata,
	output logic                                     cfg_ack,

	input  logic                                     data_ack_valid,
	input  logic [piarb_pkg::pu_id_nbits-1:0]        data_ack_port_id,
	input  logic                                     data_ack_sop,
	input  logic                                     data_ack_eop,
	input  logic [piarb_pkg::hop_info_nbits-1:0]     data_ack_data,
	input  piarb_pkg::pp_piarb_meta_t                data_ack_meta,

	output logic                                     piarb_pu_valid,
	output logic [piarb_pkg::pu_id_nbits-1:0]        piarb_pu_pid,
	output logic [piarb_pkg::hop_info_nbits-1:0]     piarb_pu_data,
	output piarb_pkg::pu_hop_meta_t                  piarb_pu_meta_data,
	output logic                                     piarb_pu_fid_sel,
	output logic                                     piarb_pu_sop,
	output logic                                     piarb_pu_eop
);

	logic                                    flow_cfg_wr;
	logic [piarb_pkg::fid_nbits-1:0]         flow_cfg_addr;
	logic [piarb_pkg::flow_pu_nbits-1:0]     flow_cfg_wdata;
	logic                                    topic_wr;
	logic [piarb_pkg::tid_nbits-1:0]         topic_waddr;
	logic [piarb_pkg::switch_tag_nbits-1:0]  topic_wdata;

	logic                                    topic_value_rd;
	logic [piarb_pkg::tid_nbits-1:0]         topic_value_raddr;
	logic [piarb_pkg::switch_tag_nbits-1:0]  topic_value_rdata;
	logic                                    flow_value_wr;
	logic [piarb_pkg::flow_pu_nbits-1:0]     flow_value_wdata;
	logic [piarb_pkg::fid_nbits-1:0]         flow_value_raddr;
	logic [piarb_pkg::fid_nbits-1:0]         flow_value_waddr;
	logic [piarb_pkg::flow_pu_nbits-1:0]     flow_value_rdata;

	piarb_cfg_port cfg_port (
		.clk, .rst_n,
		.cfg_req, .cfg_target, .cfg_addr, .cfg_wdata, .cfg_ack,
		.flow_cfg_wr, .flow_cfg_addr, .flow_cfg_wdata,
		.topic_wr, .topic_waddr, .topic_wdata
	);

	piarb_lookup lookup (
		.clk, .rst_n,
		.ecdsa_piarb_wr(flow_cfg_wr),   // flow writes pass through the lookup register
		.ecdsa_piarb_waddr(flow_cfg_addr),
		.ecdsa_piarb_wdata(flow_cfg_wdata),
		.data_ack_valid, .data_ack_port_id, .data_ack_sop, .data_ack_eop,
		.data_ack_data, .data_ack_meta,
		.flow_value_rdata, .topic_value_rdata,
		.topic_value_rd, .topic_value_raddr,
		.flow_value_wr, .flow_value_wdata, .flow_value_raddr, .flow_value_waddr,
		.piarb_pu_valid, .piarb_pu_pid, .piarb_pu_data, .piarb_pu_meta_data,
		.piarb_pu_fid_sel, .piarb_pu_sop, .piarb_pu_eop
	);

	// both tables are read for every beat, so one strobe serves both
	piarb_value_ram #(
		.depth(2 ** piarb_pkg::fid_nbits),
		.width(piarb_pkg::flow_pu_nbits),
		.read_stages(1)
	) flow_ram (
		.clk,
		.wr(flow_value_wr), .waddr(flow_value_waddr), .wdata(flow_value_wdata),
		.rd(topic_value_rd), .raddr(flow_value_raddr), .rdata(flow_value_rdata)
	);

	piarb_value_ram #(
		.depth(2 ** piarb_pkg::tid_nbits),
		.width(piarb_pkg::switch_tag_nbits),
		.read_stages(2)
	) topic_ram (
		.clk,
		.wr(topic_wr), .waddr(topic_waddr), .wdata(topic_wdata),
		.rd(topic_value_rd), .raddr(topic_value_raddr), .rdata(topic_value_rdata)
	);

endmodule

/* logic/piarb_value_ram.sv */
// table RAM with synchronous write and a read path of one or more register stages
`timescale 1ns/100ps

module piarb_value_ram #(
	parameter int depth       = 64,
	parameter int width       = 16,
	parameter int read_stages = 1
) (
	input  logic                     clk,
	input  logic                     wr,
	input  logic [$clog2(depth)-1:0] waddr,
	input  logic [width-1:0]         wdata,
	input  logic                     rd,
	input  logic [$clog2(depth)-1:0] raddr,
	output logic [width-1:0]         rdata
);

	logic [width-1:0] mem [depth];
	logic [width-1:0] rd_pipe [read_stages];   // entry 0 is the array read register

	always_ff @(posedge clk) begin
		if (wr) begin
			mem[waddr] <= wdata;
		end
	end

	// a write to the same address in this cycle is not yet visible here
	always_ff @(posedge clk) begin
		if (rd) begin
			rd_pipe[0] <= mem[raddr];
		end
	end

	for (genvar i = 1; i < read_stages; i++) begin : g_read_stage
		always_ff @(posedge clk) begin
			rd_pipe[i] <= rd_pipe[i-1];   // extra stages just follow the first one
		end
	end

	assign rdata = rd_pipe[read_stages-1];

endmodule

/* piarb_lookup/piarb_lookup.sv */
// lookup pipeline: table read issue, beat delay line, output metadata build
`timescale 1ns/100ps

module piarb_lookup (
	input  logic                                     clk,
	input  logic                                     rst_n,

	input  logic                                     ecdsa_piarb_wr,
	input  logic [piarb_pkg::fid_nbits-1:0]          ecdsa_piarb_waddr,
	input  logic [piarb_pkg::flow_pu_nbits-1:0]      ecdsa_piarb_wdata,

	input  logic                                     data_ack_valid,
	input  logic [piarb_pkg::pu_id_nbits-1:0]        data_ack_port_id,
	input  logic                                     data_ack_sop,
	input  logic                                     data_ack_eop,
	input  logic [piarb_pkg::hop_info_nbits-1:0]     data_ack_data,
	input  piarb_pkg::pp_piarb_meta_t                data_ack_meta,

	input  logic [piarb_pkg::flow_pu_nbits-1:0]      flow_value_rdata,
	input  logic [piarb_pkg::switch_tag_nbits-1:0]   topic_value_rdata,

	output logic                                     topic_value_rd,
	output logic [piarb_pkg::tid_nbits-1:0]          topic_value_raddr,

	output logic                                     flow_value_wr,
	output logic [piarb_pkg::flow_pu_nbits-1:0]      flow_value_wdata,
	output logic [piarb_pkg::fid_nbits-1:0]          flow_value_raddr,
	output logic [piarb_pkg::fid_nbits-1:0]          flow_value_waddr,

	output logic                                     piarb_pu_valid,
	output logic [piarb_pkg::pu_id_nbits-1:0]        piarb_pu_pid,
	output logic [piarb_pkg::hop_info_nbits-1:0]     piarb_pu_data,
	output piarb_pkg::pu_hop_meta_t                  piarb_pu_meta_data,
	output logic                                     piarb_pu_fid_sel,
	output logic                                     piarb_pu_sop,
	output logic                                     piarb_pu_eop
);

	// index 0 is one cycle behind the input, index 2 lines up with both read results
	logic [2:0]                                valid_d;
	logic [piarb_pkg::pu_id_nbits-1:0]         port_id_d [3];
	logic [2:0]                                sop_d;
	logic [2:0]                                eop_d;
	logic [piarb_pkg::hop_info_nbits-1:0]      data_d [3];
	piarb_pkg::pp_piarb_meta_t                 meta_d [3];

	logic [piarb_pkg::flow_pu_nbits-1:0]       flow_value_rdata_d1;   // flow table is one stage faster
	piarb_pkg::pu_hop_meta_t                   out_meta;

	// join the delayed beat with the two table values
	always_comb begin
		out_meta.creation_time = meta_d[2].creation_time;
		out_meta.rci_type      = meta_d[2].rci;
		out_meta.pkt_type      = meta_d[2].type1 ? piarb_pkg::pkt_type1 : piarb_pkg::pkt_plain;
		out_meta.switch_tag    = topic_value_rdata;
		out_meta.f_payload     = flow_value_rdata_d1;
		out_meta.fid           = meta_d[2].fid;
		out_meta.tid           = meta_d[2].tid;
	end

	always_ff @(posedge clk) begin
		topic_value_raddr <= data_ack_meta.tid;
		flow_value_raddr  <= data_ack_meta.fid;
		flow_value_waddr  <= ecdsa_piarb_waddr;
		flow_value_wdata  <= ecdsa_piarb_wdata;

		flow_value_rdata_d1 <= flow_value_rdata;

		piarb_pu_data      <= data_d[2];
		piarb_pu_pid       <= port_id_d[2];
		piarb_pu_sop       <= sop_d[2];
		piarb_pu_eop       <= eop_d[2];
		piarb_pu_fid_sel   <= meta_d[2].fid_sel;
		piarb_pu_meta_data <= out_meta;
	end

	// payload side of the delay line
	always_ff @(posedge clk) begin
		port_id_d[0] <= data_ack_port_id;
		sop_d[0]     <= data_ack_sop;
		eop_d[0]     <= data_ack_eop;
		data_d[0]    <= data_ack_data;
		meta_d[0]    <= data_ack_meta;
		for (int i = 1; i < 3; i++) begin
			port_id_d[i] <= port_id_d[i-1];
			sop_d[i]     <= sop_d[i-1];
			eop_d[i]     <= eop_d[i-1];
			data_d[i]    <= data_d[i-1];
			meta_d[i]    <= meta_d[i-1];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_d        <= '0;
			topic_value_rd <= 1'b0;
			flow_value_wr  <= 1'b0;
			piarb_pu_valid <= 1'b0;
		end else begin
			valid_d        <= {valid_d[1:0], data_ack_valid};
			topic_value_rd <= data_ack_valid;   // read strobe goes out with the addresses
			flow_value_wr  <= ecdsa_piarb_wr;
			piarb_pu_valid <= valid_d[2];
		end
	end

endmodule

/* tb/piarb_clk_gen.sv */
// testbench clock and power-on reset generator
`timescale 1ns/100ps

module piarb_clk_gen #(
	parameter int period_ns    = 20,
	parameter int reset_cycles = 2
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		rst_n <= 1'b1;   // released on a rising edge, flops still see reset there
	end

endmodule

/* tb/piarb_tb.sv */
// testbench with random table fill and rewrite, random beats, table model, compare tasks, watchdog
`timescale 1ns/100ps

module piarb_tb;

	localparam int clk_period      = 20;
	localparam int n_flow          = 2 ** piarb_pkg::fid_nbits;
	localparam int n_topic         = 2 ** piarb_pkg::tid_nbits;
	localparam int n_cfg_fill      = n_flow + n_topic;   // every entry of both tables once
	localparam int n_cfg_rewrite   = 20;
	localparam int n_beats         = 300;
	localparam int n_beats_rewrite = 100;
	localparam int watchdog_cycles = (n_cfg_fill + n_cfg_rewrite) * 10
		+ n_beats + n_beats_rewrite + 100;

	typedef struct {
		int                                       due;   // cycle count when the beat must leave
		logic [piarb_pkg::pu_id_nbits-1:0]        pid;
		logic [piarb_pkg::hop_info_nbits-1:0]     data;
		logic                                     sop;
		logic                                     eop;
		logic                                     fid_sel;
		piarb_pkg::pu_hop_meta_t                  meta;
	} exp_beat_t;

	logic                                     clk;
	logic                                     rst_n;
	logic                                     cfg_req;
	piarb_pkg::cfg_target_e                   cfg_target;
	logic [piarb_pkg::fid_nbits-1:0]          cfg_addr;
	logic [piarb_pkg::flow_pu_nbits-1:0]      cfg_wdata;
	logic                                     cfg_ack;
	logic                                     data_ack_valid;
	logic [piarb_pkg::pu_id_nbits-1:0]        data_ack_port_id;
	logic                                     data_ack_sop;
	logic                                     data_ack_eop;
	logic [piarb_pkg::hop_info_nbits-1:0]     data_ack_data;
	piarb_pkg::pp_piarb_meta_t                data_ack_meta;
	logic                                     piarb_pu_valid;
	logic [piarb_pkg::pu_id_nbits-1:0]        piarb_pu_pid;
	logic [piarb_pkg::hop_info_nbits-1:0]     piarb_pu_data;
	piarb_pkg::pu_hop_meta_t                  piarb_pu_meta_data;
	logic                                     piarb_pu_fid_sel;
	logic                                     piarb_pu_sop;
	logic                                     piarb_pu_eop;

	logic [piarb_pkg::flow_pu_nbits-1:0]      flow_model [n_flow];
	logic [piarb_pkg::switch_tag_nbits-1:0]   topic_model [n_topic];
	exp_beat_t                                exp_q [$];
	int                                       cycle = 0;
	logic                                     ack_prev = 1'b0;
	int checks          = 0;
	int meta_errors     = 0;
	int data_errors     = 0;
	int flag_errors     = 0;
	int timing_errors   = 0;
	int protocol_errors = 0;

	piarb_clk_gen #(.period_ns(clk_period), .reset_cycles(2)) clk_gen0 (.clk, .rst_n);

	piarb_top dut0 (.*);

	always @(posedge clk) cycle <= cycle + 1;

	task automatic compare_meta(input string what, input piarb_pkg::pu_hop_meta_t got,
			input piarb_pkg::pu_hop_meta_t expected);
		checks++;
		if (got !== expected) begin
			meta_errors++;
			$display("Error %0t: %s got %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic compare_data(input string what, input logic [piarb_pkg::hop_info_nbits-1:0] got,
			input logic [piarb_pkg::hop_info_nbits-1:0] expected);
		checks++;
		if (got !== expected) begin
			data_errors++;
			$display("Error %0t: %s got %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic compare_flags(input string what, input logic got, input logic expected);
		checks++;
		if (got !== expected) begin
			flag_errors++;
			$display("Error %0t: %s got %b, expected %b", $time, what, got, expected);
		end
	endtask

	// runs one four-phase transfer and updates the model once the ack has come and gone
	task automatic cfg_transfer(input piarb_pkg::cfg_target_e target,
			input logic [piarb_pkg::fid_nbits-1:0] addr,
			input logic [piarb_pkg::flow_pu_nbits-1:0] wdata);
		int waited;
		@(posedge clk);
		cfg_req    <= 1'b1;
		cfg_target <= target;
		cfg_addr   <= addr;
		cfg_wdata  <= wdata;
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
		end while (cfg_ack !== 1'b1 && waited < 10);
		if (cfg_ack !== 1'b1) begin
			protocol_errors++;
			$display("no cfg_ack within 10 cycles for %s write to address %h", target.name(), addr);
		end
		cfg_req <= 1'b0;
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
		end while (cfg_ack !== 1'b0 && waited < 10);
		if (cfg_ack !== 1'b0) begin
			protocol_errors++;
			$display("cfg_ack stayed high after cfg_req was dropped, address %h", addr);
		end
		if (target == piarb_pkg::cfg_flow) begin
			flow_model[addr] = wdata;
		end else begin
			topic_model[addr[piarb_pkg::tid_nbits-1:0]] = wdata[piarb_pkg::switch_tag_nbits-1:0];
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			data_ack_valid <= 1'b0;
		end
	endtask

	task automatic send_beat();
		exp_beat_t                  beat;
		piarb_pkg::pp_piarb_meta_t  meta;
		meta      = $urandom();
		beat.pid  = $urandom();
		beat.data = $urandom();
		beat.sop  = $urandom();
		beat.eop  = $urandom();
		beat.fid_sel              = meta.fid_sel;
		beat.meta.creation_time   = meta.creation_time;
		beat.meta.rci_type        = meta.rci;
		beat.meta.pkt_type        = meta.type1 ? piarb_pkg::pkt_type1 : piarb_pkg::pkt_plain;
		beat.meta.switch_tag      = topic_model[meta.tid];
		beat.meta.f_payload       = flow_model[meta.fid];
		beat.meta.fid             = meta.fid;
		beat.meta.tid             = meta.tid;
		@(posedge clk);
		data_ack_valid   <= 1'b1;
		data_ack_port_id <= beat.pid;
		data_ack_sop     <= beat.sop;
		data_ack_eop     <= beat.eop;
		data_ack_data    <= beat.data;
		data_ack_meta    <= meta;
		beat.due = cycle + 1 + piarb_pkg::lookup_latency;   // cycle has not yet counted this edge
		exp_q.push_back(beat);
	endtask

	task automatic send_beats(input int n);
		for (int i = 0; i < n; i++) begin
			send_beat();
			if ($urandom() % 8 == 0) begin
				idle_cycles(1 + $urandom() % 2);
			end
		end
		idle_cycles(1);
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_q.size() > 0 && waited < piarb_pkg::lookup_latency + 10) begin
			@(posedge clk);
			waited++;
		end
		if (exp_q.size() > 0) begin
			protocol_errors++;
			$display("%0d sent beats never came out of the DUT", exp_q.size());
			exp_q.delete();
		end
	endtask

	// outputs and the handshake are sampled on the falling edge
	always @(negedge clk) begin : output_monitor
		exp_beat_t beat;
		if (rst_n) begin
			if (cfg_ack && !ack_prev && !cfg_req) begin
				protocol_errors++;
				$display("cfg_ack rose at %0t while cfg_req was low", $time);
			end
			if (!cfg_ack && ack_prev && cfg_req) begin
				protocol_errors++;
				$display("cfg_ack fell at %0t before cfg_req was dropped", $time);
			end
			ack_prev = cfg_ack;
			while (exp_q.size() > 0 && exp_q[0].due < cycle) begin
				beat = exp_q.pop_front();
				timing_errors++;
				$display("Error %0t: beat due at cycle %0d never appeared", $time, beat.due);
			end
			if (piarb_pu_valid === 1'b1) begin
				if (exp_q.size() == 0) begin
					protocol_errors++;
					$display("output beat at %0t matches no beat that was sent", $time);
				end else begin
					beat = exp_q.pop_front();
					if (beat.due != cycle) begin
						timing_errors++;
						$display("Error %0t: beat left at cycle %0d, expected cycle %0d",
							$time, cycle, beat.due);
					end
					compare_data("hop data", piarb_pu_data, beat.data);
					compare_data("port id", piarb_pu_pid, beat.pid);
					compare_flags("sop", piarb_pu_sop, beat.sop);
					compare_flags("eop", piarb_pu_eop, beat.eop);
					compare_flags("fid_sel", piarb_pu_fid_sel, beat.fid_sel);
					compare_meta("output metadata", piarb_pu_meta_data, beat.meta);
				end
			end
		end
	end

	initial begin
		#(watchdog_cycles * clk_period);
		$display("watchdog expired after %0d clock periods, the run hung", watchdog_cycles);
		$display("Some tests failed");
		$finish;
	end

	initial begin : stimulus
		int                              order [n_cfg_fill];
		int                              j;
		int                              tmp;
		int                              total;
		logic [piarb_pkg::fid_nbits-1:0] addr;
		void'($urandom(12229));
		cfg_req          <= 1'b0;
		cfg_target       <= piarb_pkg::cfg_flow;
		cfg_addr         <= '0;
		cfg_wdata        <= '0;
		data_ack_valid   <= 1'b0;
		data_ack_port_id <= '0;
		data_ack_sop     <= 1'b0;
		data_ack_eop     <= 1'b0;
		data_ack_data    <= '0;
		data_ack_meta    <= '0;
		@(posedge rst_n);
		repeat (3) begin
			@(negedge clk);
			compare_flags("piarb_pu_valid after reset", piarb_pu_valid, 1'b0);
			compare_flags("cfg_ack after reset", cfg_ack, 1'b0);
		end
		for (int i = 0; i < n_cfg_fill; i++) order[i] = i;
		for (int i = n_cfg_fill - 1; i > 0; i--) begin
			j = $urandom() % (i + 1);   // shuffle so flow and topic writes interleave
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		for (int i = 0; i < n_cfg_fill; i++) begin
			if (order[i] < n_flow) begin
				cfg_transfer(piarb_pkg::cfg_flow, order[i], $urandom());
			end else begin
				addr = $urandom();   // high bits are don't care for the topic table
				addr[piarb_pkg::tid_nbits-1:0] = order[i] - n_flow;
				cfg_transfer(piarb_pkg::cfg_topic, addr, $urandom());
			end
		end
		send_beats(n_beats);
		wait_drain();
		for (int i = 0; i < n_cfg_rewrite; i++) begin
			cfg_transfer(($urandom() % 2) ? piarb_pkg::cfg_topic : piarb_pkg::cfg_flow,
				$urandom(), $urandom());
		end
		send_beats(n_beats_rewrite);
		wait_drain();
		total = meta_errors + data_errors + flag_errors + timing_errors + protocol_errors;
		$display("checks %0d, errors: meta %0d, data %0d, flags %0d, timing %0d, protocol %0d",
			checks, meta_errors, data_errors, flag_errors, timing_errors, protocol_errors);
		if (total == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* vlog.f */
common/piarb_pkg.sv
logic/piarb_value_ram.sv
logic/piarb_cfg_port.sv
piarb_lookup/piarb_lookup.sv
logic/piarb_top.sv
tb/piarb_clk_gen.sv
tb/piarb_tb.sv
